// ==== compile.f ====
rtl/updi_pkg.sv
rtl/updi_instr_if.sv
rtl/updi_frame_tx.sv
rtl/updi_rx_collect.sv
rtl/updi_session_seq.sv
rtl/updi_programmer.sv
verif/updi_target_model.sv
verif/tb_updi_programmer.sv

// ==== Bender.yml ====
package:
  name: updi_programmer

sources:
  - rtl/updi_pkg.sv
  - rtl/updi_instr_if.sv
  - rtl/updi_frame_tx.sv
  - rtl/updi_rx_collect.sv
  - rtl/updi_session_seq.sv
  - rtl/updi_programmer.sv
  - target: test
    files:
      - verif/updi_target_model.sv
      - verif/tb_updi_programmer.sv

// ==== verif/tb_updi_programmer.sv ====
// Testbench running a table of target profiles against the UPDI session controller
`default_nettype none
`timescale 1ns/1ps

module tb_updi_programmer;

	localparam int NUM_CASES = 8;
	localparam int WAIT_LIMIT = 2000;

	typedef struct packed {
		logic [7:0]  statusa;
		logic [7:0]  key_status;
		logic [3:0]  polls;
		logic [7:0]  ack;
		logic        silent;
		logic [23:0] id;
		logic        exp_done;
		logic [23:0] exp_id;
	} scenario_t;

	logic        clk;
	logic        rst;
	logic        start;
	logic [7:0]  tx_data;
	logic        tx_valid;
	logic [7:0]  rx_data;
	logic        rx_valid;
	logic        double_break_start;
	logic        double_break_done;
	logic        busy;
	logic        done;
	logic        error;
	logic [23:0] device_id;

	logic [7:0]  cfg_statusa;
	logic [7:0]  cfg_key_status;
	logic [3:0]  cfg_polls;
	logic [7:0]  cfg_ack;
	logic        cfg_silent;
	logic [23:0] cfg_id;
	logic        frame_check;
	logic [1:0]  frame_kind;
	logic [63:0] frame_got;
	logic [63:0] frame_exp;
	logic [3:0]  checked_count;

	scenario_t scenarios [0:NUM_CASES-1];

	updi_programmer #(
		.DELAY_CLKS  (8),
		.TIMEOUT_CLKS(40),
		.MAX_POLLS   (3)
	) updi_programmer_inst (.*);

	updi_target_model target_inst (
		.*,
		.statusa        (cfg_statusa),
		.key_status     (cfg_key_status),
		.not_ready_polls(cfg_polls),
		.ack_value      (cfg_ack),
		.silent         (cfg_silent),
		.id_bytes       (cfg_id)
	);

	always #10 clk = ~clk;

	task stop_on_failure();
		$display("Regression failed");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	function string frame_label(input logic [1:0] kind);
		case (kind)
			2'd0: return "NVMPROG key frame";
			2'd1: return "reset request frame";
			default: return "SIB pointer frame";
		endcase
	endfunction

	// frame contents are checked as the model decodes them
	always @(posedge clk) begin
		if (frame_check) begin
			check_value(frame_got, frame_exp, frame_label(frame_kind));
		end
	end

	task run_session(input scenario_t sc, output logic got_done, output logic got_error);
		int cycles;
		@(posedge clk);
		cfg_statusa <= sc.statusa;
		cfg_key_status <= sc.key_status;
		cfg_polls <= sc.polls;
		cfg_ack <= sc.ack;
		cfg_silent <= sc.silent;
		cfg_id <= sc.id;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		got_done = 1'b0;
		got_error = 1'b0;
		cycles = 0;
		while (!got_done && !got_error) begin
			@(posedge clk);
			got_done = done;
			got_error = error;
			check_value(busy, 1'b1, "busy while the session runs");
			cycles++;
			if (!got_done && !got_error && cycles >= WAIT_LIMIT) begin
				$display("Timeout: no done or error within %0d cycles of start", WAIT_LIMIT);
				stop_on_failure();
			end
		end
	endtask

	initial begin
		logic got_done;
		logic got_error;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		cfg_statusa = '0;
		cfg_key_status = '0;
		cfg_polls = '0;
		cfg_ack = '0;
		cfg_silent = 1'b0;
		cfg_id = '0;
		// statusa, key status, failed polls, ack, silent, id, done expected, device_id
		scenarios[0] = '{8'h01, 8'h10, 4'd0, 8'h40, 1'b0, 24'h22931E, 1'b1, 24'h22931E};
		scenarios[1] = '{8'h00, 8'h10, 4'd0, 8'h40, 1'b0, 24'h22931E, 1'b0, 24'h000000};
		scenarios[2] = '{8'h01, 8'hEF, 4'd0, 8'h40, 1'b0, 24'h22931E, 1'b0, 24'h000000};
		scenarios[3] = '{8'h30, 8'h10, 4'd2, 8'h40, 1'b0, 24'h0B9530, 1'b1, 24'h0B9530};
		scenarios[4] = '{8'h30, 8'h10, 4'd4, 8'h40, 1'b0, 24'h0B9530, 1'b0, 24'h000000};
		scenarios[5] = '{8'h01, 8'h10, 4'd0, 8'h41, 1'b0, 24'h22931E, 1'b0, 24'h000000};
		scenarios[6] = '{8'h01, 8'h10, 4'd0, 8'h40, 1'b1, 24'h22931E, 1'b0, 24'h000000};
		scenarios[7] = '{8'h82, 8'h1F, 4'd1, 8'h40, 1'b0, 24'hA5C35A, 1'b1, 24'hA5C35A};
		repeat (5) @(posedge clk);
		check_value(tx_valid, 1'b0, "tx_valid after reset");
		check_value(double_break_start, 1'b0, "double_break_start after reset");
		check_value(busy, 1'b0, "busy after reset");
		check_value(done | error, 1'b0, "done or error after reset");
		check_value(device_id, 24'h0, "device_id after reset");
		rst <= 1'b0;
		for (int i = 0; i < NUM_CASES; i++) begin
			run_session(scenarios[i], got_done, got_error);
			check_value(got_done, scenarios[i].exp_done, "session done");
			check_value(got_error, !scenarios[i].exp_done, "session error");
			check_value(device_id, scenarios[i].exp_id, "device_id");
			if (scenarios[i].exp_done) begin
				// key, reset set, reset clear and pointer frames
				check_value(checked_count, 4'd4, "checked frames per session");
			end
			@(posedge clk);
			check_value(busy, 1'b0, "busy after the closing strobe");
			check_value(done | error, 1'b0, "closing strobe longer than one cycle");
		end
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/updi_target_model.sv ====
// Behavioral UPDI target for the testbench, decodes each frame and answers from a configured profile
`default_nettype none
`timescale 1ns/1ps

module updi_target_model import updi_pkg::*; (
	input  wire         clk,
	input  wire  [7:0]  tx_data,
	input  wire         tx_valid,
	output logic [7:0]  rx_data,
	output logic        rx_valid,
	input  wire         double_break_start,
	output logic        double_break_done,
	input  wire  [7:0]  statusa,
	input  wire  [7:0]  key_status,
	input  wire  [3:0]  not_ready_polls,
	input  wire  [7:0]  ack_value,
	input  wire         silent,
	input  wire  [23:0] id_bytes,
	output logic        frame_check,
	output logic [1:0]  frame_kind,
	output logic [63:0] frame_got,
	output logic [63:0] frame_exp,
	output logic [3:0]  checked_count
);

	integer     seed;
	logic [7:0] frame [0:9];
	int         nbytes;
	logic [7:0] reply_q [$];
	int         gap;
	int         brk_cnt;
	int         polls;
	int         stcs_n;
	logic [7:0] repeat_n;

	initial begin
		seed = 95700;
		nbytes = 0;
		gap = 0;
		brk_cnt = 0;
		polls = 0;
		stcs_n = 0;
		repeat_n = '0;
		rx_data = '0;
		rx_valid = 1'b0;
		double_break_done = 1'b0;
		frame_check = 1'b0;
		frame_kind = '0;
		frame_got = '0;
		frame_exp = '0;
		checked_count = '0;
	end

	// a silent target still takes the frame, it just never answers
	task queue_reply(input logic [7:0] value);
		if (!silent) begin
			reply_q.push_back(value);
		end
		gap = 1 + ({$random(seed)} % 10);
	endtask

	task report_frame(input logic [1:0] kind, input logic [63:0] got, input logic [63:0] exp);
		frame_check <= 1'b1;
		frame_kind <= kind;
		frame_got <= got;
		frame_exp <= exp;
		checked_count <= checked_count + 4'd1;
	endtask

	task decode_frame();
		updi_opcode_u opc;
		logic [63:0]  key_got;
		opc = frame[1];
		case (opc.cs_view.op)
			UPDI_LDCS: begin
				if (opc.cs_view.cs_addr == CS_STATUSA) begin
					queue_reply(statusa);
				end else if (opc.cs_view.cs_addr == CS_KEY_STATUS) begin
					queue_reply(key_status);
				end else if (polls < not_ready_polls) begin
					// programming mode bit 3 still clear
					polls++;
					queue_reply(8'h00);
				end else begin
					queue_reply(8'h08);
				end
			end
			UPDI_KEY: begin
				// key bytes arrive least significant first
				for (int i = 0; i < 8; i++) begin
					key_got[8*i +: 8] = frame[2 + i];
				end
				report_frame(2'd0, key_got, KEY_NVMPROG);
			end
			UPDI_STCS: begin
				report_frame(2'd1, {frame[1][3:0], frame[2]},
					{CS_RESET_REQ, ((stcs_n == 0) ? RESET_SIGNATURE : 8'h00)});
				stcs_n++;
			end
			UPDI_ST: begin
				report_frame(2'd2, {frame[3], frame[2]}, SIB_BASE_ADDR);
				queue_reply(ack_value);
			end
			UPDI_REPEAT: repeat_n = frame[2];
			UPDI_LD: begin
				for (int i = 0; i <= repeat_n && i < 3; i++) begin
					queue_reply(id_bytes[8*i +: 8]);
				end
				repeat_n = '0;
			end
			default: ;
		endcase
	endtask

	always @(posedge clk) begin
		rx_valid <= 1'b0;
		frame_check <= 1'b0;
		double_break_done <= 1'b0;
		if (double_break_start) begin
			// every session starts from a clean target
			brk_cnt = 5;
			polls = 0;
			stcs_n = 0;
			repeat_n = '0;
			reply_q.delete();
			checked_count <= '0;
		end else if (brk_cnt > 0) begin
			brk_cnt--;
			if (brk_cnt == 0) begin
				double_break_done <= 1'b1;
			end
		end
		// frames are separated by at least one idle cycle
		if (tx_valid) begin
			if (nbytes < 10) begin
				frame[nbytes] = tx_data;
			end
			nbytes++;
		end else if (nbytes > 0) begin
			decode_frame();
			nbytes = 0;
		end
		if (gap > 0) begin
			gap--;
		end else if (reply_q.size() > 0) begin
			rx_data <= reply_q.pop_front();
			rx_valid <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/updi_programmer.sv ====
// Top level of the UPDI session controller, driving a UART PHY that handles break and echo
`default_nettype none
`timescale 1ns/1ps

module updi_programmer #(
	parameter int DELAY_CLKS = 100,
	parameter int TIMEOUT_CLKS = 100,
	parameter int MAX_POLLS = 8
) (
	input  wire         clk,
	input  wire         rst,
	output logic [7:0]  tx_data,
	output logic        tx_valid,
	input  wire  [7:0]  rx_data,
	input  wire         rx_valid,
	output logic        double_break_start,
	input  wire         double_break_done,
	input  wire         start,
	output logic        busy,
	output logic        done,
	output logic        error,
	output logic [23:0] device_id
);

	updi_instr_if instr_bus ();
	updi_resp_if  resp_bus ();

	// reply owed by the frame just sent
	logic       expect_valid;
	logic [1:0] expect_count;
	logic       expect_ack;

	updi_session_seq #(
		.DELAY_CLKS(DELAY_CLKS),
		.MAX_POLLS (MAX_POLLS)
	) session_seq_inst (
		.*,
		.instr(instr_bus),
		.resp (resp_bus)
	);

	updi_frame_tx frame_tx_inst (
		.*,
		.instr(instr_bus)
	);

	updi_rx_collect #(
		.TIMEOUT_CLKS(TIMEOUT_CLKS)
	) rx_collect_inst (
		.*,
		.resp(resp_bus)
	);

endmodule

`default_nettype wire

// ==== rtl/updi_session_seq.sv ====
// Session FSM instantiated by the top level to unlock NVMPROG mode and read the signature
`default_nettype none
`timescale 1ns/1ps

module updi_session_seq import updi_pkg::*; #(
	parameter int DELAY_CLKS = 100,
	parameter int MAX_POLLS = 8
) (
	input  wire         clk,
	input  wire         rst,
	input  wire         start,
	input  wire         double_break_done,
	output logic        double_break_start,
	output logic        busy,
	output logic        done,
	output logic        error,
	output logic [23:0] device_id,
	updi_instr_if.seq   instr,
	updi_resp_if.seq    resp
);

	localparam int DW = $clog2(DELAY_CLKS + 1);
	localparam int PW = $clog2(MAX_POLLS + 1);

	// frame states advance in declaration order and the poll wait sits at the end
	typedef enum logic [3:0] {
		S_IDLE, S_BREAK, S_RD_STATUSA, S_KEY, S_RD_KEY_STATUS, S_RST_SET, S_RST_WAIT,
		S_RST_CLR, S_RD_SYS_STATUS, S_SET_PTR, S_REPEAT, S_LD, S_POLL_WAIT
	} state_e;

	state_e        state;
	state_e        prev_state;
	logic          issue;
	logic          step;
	logic          pass;
	logic [7:0]    status;
	logic [DW-1:0] delay_cnt;
	logic          delay_done;
	logic [PW-1:0] poll_cnt;

	assign status = resp.resp_data[0];
	assign delay_done = (delay_cnt == DW'(DELAY_CLKS - 1));
	// one start on entry to each frame state
	assign instr.start = issue && (state != prev_state);
	// frames with a reply finish on resp_done and the others on tx_done
	assign step = (instr.opcode.cs_view.op inside {UPDI_LDCS, UPDI_LD, UPDI_ST})
		? resp.resp_done : instr.tx_done;

	always_comb begin
		issue = 1'b1;
		instr.opcode = '0;
		instr.payload = '0;
		instr.payload_len = 4'd0;
		case (state)
			S_RD_STATUSA: instr.opcode.cs_view = '{UPDI_LDCS, 1'b0, CS_STATUSA};
			S_KEY: begin
				// zero low nibble selects the 64-bit key
				instr.opcode.cs_view = '{UPDI_KEY, 1'b0, 4'h0};
				instr.payload = KEY_NVMPROG;
				instr.payload_len = 4'd8;
			end
			S_RD_KEY_STATUS: instr.opcode.cs_view = '{UPDI_LDCS, 1'b0, CS_KEY_STATUS};
			S_RST_SET, S_RST_CLR: begin
				instr.opcode.cs_view = '{UPDI_STCS, 1'b0, CS_RESET_REQ};
				instr.payload[0] = (state == S_RST_SET) ? RESET_SIGNATURE : 8'h00;
				instr.payload_len = 4'd1;
			end
			S_RD_SYS_STATUS: instr.opcode.cs_view = '{UPDI_LDCS, 1'b0, CS_SYS_STATUS};
			S_SET_PTR: begin
				instr.opcode.ptr_view = '{UPDI_ST, 1'b0, PTR_ADDR, SIZE_WORD};
				instr.payload[1:0] = SIB_BASE_ADDR;
				instr.payload_len = 4'd2;
			end
			S_REPEAT: begin
				// two repeats give three reads
				instr.opcode.ptr_view = '{UPDI_REPEAT, 1'b0, 2'b00, SIZE_BYTE};
				instr.payload[0] = 8'd2;
				instr.payload_len = 4'd1;
			end
			S_LD: instr.opcode.ptr_view = '{UPDI_LD, 1'b0, PTR_INC, SIZE_BYTE};
			default: issue = 1'b0;
		endcase
	end

	always_comb begin
		case (state)
			S_RD_STATUSA: pass = (status != 8'h00);
			S_RD_KEY_STATUS: pass = status[KEY_STATUS_NVMPROG_BIT];
			S_RD_SYS_STATUS: pass = status[SYS_STATUS_PROG_BIT];
			default: pass = 1'b1;
		endcase
	end

	// shared by the reset pulse and the poll spacing
	always_ff @(posedge clk) begin
		if (rst || (state != S_RST_WAIT && state != S_POLL_WAIT)) begin
			delay_cnt <= '0;
		end else begin
			delay_cnt <= delay_cnt + DW'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			prev_state <= S_IDLE;
			busy <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
			double_break_start <= 1'b0;
			poll_cnt <= '0;
			device_id <= '0;
		end else begin
			prev_state <= state;
			done <= 1'b0;
			error <= 1'b0;
			double_break_start <= 1'b0;
			// busy stays up through the closing strobe
			if (done || error) begin
				busy <= 1'b0;
			end
			if (state != S_IDLE && (resp.timeout || resp.ack_error)) begin
				state <= S_IDLE;
				error <= 1'b1;
			end else begin
				case (state)
					S_IDLE: begin
						if (start && !busy) begin
							busy <= 1'b1;
							device_id <= '0;
							poll_cnt <= '0;
							double_break_start <= 1'b1;
							state <= S_BREAK;
						end
					end
					S_BREAK: begin
						if (double_break_done) begin
							state <= S_RD_STATUSA;
						end
					end
					S_RST_WAIT: begin
						if (delay_done) begin
							state <= S_RST_CLR;
						end
					end
					S_POLL_WAIT: begin
						if (delay_done) begin
							state <= S_RD_SYS_STATUS;
						end
					end
					default: begin
						if (step && pass) begin
							state <= (state == S_LD) ? S_IDLE : state_e'(state + 4'd1);
							if (state == S_LD) begin
								device_id <= resp.resp_data;
								done <= 1'b1;
							end
						end else if (step && state == S_RD_SYS_STATUS
								&& poll_cnt != PW'(MAX_POLLS - 1)) begin
							poll_cnt <= poll_cnt + PW'(1);
							state <= S_POLL_WAIT;
						end else if (step) begin
							state <= S_IDLE;
							error <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	// a reply strobe outside a reply wait would be dropped and leave the session without an end
	a_reply_in_wait: assert property (@(posedge clk) disable iff (rst)
		(resp.resp_done || resp.timeout || resp.ack_error)
		|-> state inside {S_RD_STATUSA, S_RD_KEY_STATUS, S_RD_SYS_STATUS, S_SET_PTR, S_LD});

endmodule

`default_nettype wire

// ==== rtl/updi_rx_collect.sv ====
// Gathers the reply bytes of a frame, checks an expected ACK and times out a silent target
`default_nettype none
`timescale 1ns/1ps

module updi_rx_collect import updi_pkg::*; #(
	parameter int TIMEOUT_CLKS = 100
) (
	input  wire          clk,
	input  wire          rst,
	input  wire  [7:0]   rx_data,
	input  wire          rx_valid,
	input  wire          expect_valid,
	input  wire  [1:0]   expect_count,
	input  wire          expect_ack,
	updi_resp_if.collect resp
);

	localparam int TW = $clog2(TIMEOUT_CLKS + 1);

	logic [1:0]    pending;
	logic [1:0]    got;
	logic          ack_q;
	logic [TW-1:0] idle_cnt;
	updi_resp_t    data_q;
	logic          final_byte;
	logic          ack_bad;

	assign final_byte = rx_valid && (pending == 2'd1);
	assign ack_bad = ack_q && (rx_data != ACK_BYTE);
	assign resp.resp_done = final_byte && !ack_bad;
	assign resp.ack_error = final_byte && ack_bad;
	assign resp.timeout = (pending != 2'd0) && !rx_valid && (idle_cnt == TW'(TIMEOUT_CLKS - 1));

	// arriving byte shows up together with resp_done
	always_comb begin
		resp.resp_data = data_q;
		if (rx_valid && pending != 2'd0) begin
			resp.resp_data[got] = rx_data;
		end
	end

	always_ff @(posedge clk) begin
		data_q <= resp.resp_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= '0;
			got <= '0;
			ack_q <= 1'b0;
			idle_cnt <= '0;
		end else if (expect_valid) begin
			pending <= expect_count;
			got <= '0;
			ack_q <= expect_ack;
			idle_cnt <= '0;
		end else if (pending != 2'd0) begin
			if (rx_valid) begin
				pending <= pending - 2'd1;
				got <= got + 2'd1;
				idle_cnt <= '0;
			end else if (resp.timeout) begin
				pending <= '0;
			end else begin
				idle_cnt <= idle_cnt + TW'(1);
			end
		end
	end

	// the sequencer waits for each reply before it sends the next frame
	a_no_overlap: assert property (@(posedge clk) disable iff (rst)
		expect_valid |-> pending == 2'd0);

endmodule

`default_nettype wire

// ==== rtl/updi_frame_tx.sv ====
// Sends one UPDI frame on the TX strobe and tells the collector which reply the frame must produce
`default_nettype none
`timescale 1ns/1ps

module updi_frame_tx import updi_pkg::*; (
	input  wire        clk,
	input  wire        rst,
	updi_instr_if.tx   instr,
	output logic [7:0] tx_data,
	output logic       tx_valid,
	output logic       expect_valid,
	output logic [1:0] expect_count,
	output logic       expect_ack
);

	updi_op_e      op;
	updi_opcode_u  opcode_q;
	updi_payload_t payload_q;
	logic [3:0]    len_q;
	logic [3:0]    idx;
	logic          active;
	logic          last;
	logic [1:0]    count_next;
	logic          ack_next;
	logic [1:0]    repeat_q;

	// the class bits sit at the same place in both views
	assign op = instr.opcode.cs_view.op;

	// idx 0 is sync, 1 the opcode, then the payload bytes
	assign last = active && (idx == len_q + 4'd1);
	assign tx_valid = active;
	assign instr.tx_done = last;
	assign expect_valid = last;

	always_comb begin
		case (idx)
			4'd0: tx_data = SYNC_BYTE;
			4'd1: tx_data = opcode_q;
			default: tx_data = payload_q[0];
		endcase
	end

	// reply size from the class first, then from the fields of its view
	always_comb begin
		count_next = 2'd0;
		ack_next = 1'b0;
		case (op)
			UPDI_LDCS: count_next = 2'd1;
			UPDI_LD: count_next = repeat_q + 2'd1;
			UPDI_ST: begin
				// only a pointer write is answered by a single ACK
				if (instr.opcode.ptr_view.ptr == PTR_ADDR) begin
					count_next = 2'd1;
					ack_next = 1'b1;
				end
			end
			default: count_next = 2'd0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			idx <= '0;
			expect_count <= '0;
			expect_ack <= 1'b0;
			repeat_q <= '0;
		end else if (instr.start) begin
			active <= 1'b1;
			idx <= '0;
			expect_count <= count_next;
			expect_ack <= ack_next;
			if (op == UPDI_REPEAT) begin
				// the collector holds three bytes at most
				repeat_q <= (instr.payload[0] > 8'd2) ? 2'd2 : instr.payload[0][1:0];
			end else if (op == UPDI_LD) begin
				repeat_q <= '0;
			end
		end else if (active) begin
			active <= !last;
			idx <= idx + 4'd1;
		end
	end

	// payload drains from byte 0 as each payload byte leaves
	always_ff @(posedge clk) begin
		if (instr.start) begin
			opcode_q <= instr.opcode;
			payload_q <= instr.payload;
			len_q <= instr.payload_len;
		end else if (active && idx >= 4'd2) begin
			payload_q <= payload_q >> 8;
		end
	end

	a_payload_len: assert property (@(posedge clk) disable iff (rst)
		instr.start |-> instr.payload_len <= 4'd8);

endmodule

`default_nettype wire

// ==== rtl/updi_instr_if.sv ====
// Handshakes between the session sequencer, the frame transmitter and the response collector
`default_nettype none
`timescale 1ns/1ps

// one frame per start strobe, fields sampled only with start
interface updi_instr_if import updi_pkg::*; ();
	logic          start;
	updi_opcode_u  opcode;
	updi_payload_t payload;
	logic [3:0]    payload_len;
	logic          tx_done;

	modport seq (output start, opcode, payload, payload_len, input tx_done);
	modport tx (input start, opcode, payload, payload_len, output tx_done);
endinterface

// strobes from the collector, resp_data holds between replies
interface updi_resp_if import updi_pkg::*; ();
	logic       resp_done;
	updi_resp_t resp_data;
	logic       timeout;
	logic       ack_error;

	modport collect (output resp_done, resp_data, timeout, ack_error);
	modport seq (input resp_done, resp_data, timeout, ack_error);
endinterface

`default_nettype wire

// ==== rtl/updi_pkg.sv ====
// UPDI opcodes, register addresses and frame types, imported by the session controller blocks
`default_nettype none

package updi_pkg;

	// instruction class in opcode bits 7:5
	typedef enum logic [2:0] {
		UPDI_LD     = 3'b001,
		UPDI_ST     = 3'b011,
		UPDI_LDCS   = 3'b100,
		UPDI_REPEAT = 3'b101,
		UPDI_STCS   = 3'b110,
		UPDI_KEY    = 3'b111
	} updi_op_e;

	typedef struct packed {
		updi_op_e   op;
		logic       zero;
		logic [3:0] cs_addr;
	} updi_cs_view_t;

	typedef struct packed {
		updi_op_e   op;
		logic       zero;
		logic [1:0] ptr;
		logic [1:0] size;
	} updi_ptr_view_t;

	// control/status access carries an address, LD/ST/REPEAT a pointer mode and size
	typedef union packed {
		updi_cs_view_t  cs_view;
		updi_ptr_view_t ptr_view;
	} updi_opcode_u;

	// byte 0 goes out first
	typedef logic [7:0][7:0] updi_payload_t;
	// first received byte in byte 0
	typedef logic [2:0][7:0] updi_resp_t;

	localparam logic [7:0] SYNC_BYTE = 8'h55;
	localparam logic [7:0] ACK_BYTE = 8'h40;
	localparam logic [7:0] RESET_SIGNATURE = 8'h59;

	localparam logic [3:0] CS_STATUSA = 4'h0;
	localparam logic [3:0] CS_KEY_STATUS = 4'h7;
	localparam logic [3:0] CS_RESET_REQ = 4'h8;
	localparam logic [3:0] CS_SYS_STATUS = 4'hB;

	localparam logic [15:0] SIB_BASE_ADDR = 16'h1100;
	// ascii "NVMProg " with the first character on top, so the space leaves first
	localparam logic [63:0] KEY_NVMPROG = 64'h4E56_4D50_726F_6720;

	localparam int KEY_STATUS_NVMPROG_BIT = 4;
	localparam int SYS_STATUS_PROG_BIT = 3;

	localparam logic [1:0] PTR_INC = 2'b01;
	localparam logic [1:0] PTR_ADDR = 2'b10;
	localparam logic [1:0] SIZE_BYTE = 2'b00;
	localparam logic [1:0] SIZE_WORD = 2'b01;

endpackage

`default_nettype wire
